// ==== test/spi_msg_patterns.txt ====
# name message response led img_rst_ header, all values in hex
# response is only compared for type codes with bit 7 set
nop_first    0000000000000000 0000000000000000 0 0 0000000000000000000000000000
echo_a       810123456789ABCD 0123456789ABCD00 0 0 0000000000000000000000000000
echo_ones    81FFFFFFFFFFFFFF FFFFFFFFFFFFFF00 0 0 0000000000000000000000000000
echo_zero    8100000000000000 0000000000000000 0 0 0000000000000000000000000000
echo_alt     81A5A5A5A5A5A5A5 A5A5A5A5A5A5A500 0 0 0000000000000000000000000000
status_rst   8600000000000000 0000000000000000 0 0 0000000000000000000000000000
led_set_5    0200000000000005 0000000000000000 5 0 0000000000000000000000000000
led_set_hi   02FFFFFFFFFFFFFA 0000000000000000 A 0 0000000000000000000000000000
img_run      0300000000000001 0000000000000000 A 1 0000000000000000000000000000
status_a     8600000000000000 A800000000000000 A 1 0000000000000000000000000000
led_set_3    0200000000000003 0000000000000000 3 1 0000000000000000000000000000
status_b     86123456789ABCDE 3800000000000000 3 1 0000000000000000000000000000
img_hold     03FFFFFFFFFFFFFE 0000000000000000 3 0 0000000000000000000000000000
status_c     8600000000000000 3000000000000000 3 0 0000000000000000000000000000
hdr1_a       0400112233445566 0000000000000000 3 0 0011223344556600000000000000
hdr2_a       058899AABBCCDDEE 0000000000000000 3 0 001122334455668899AABBCCDDEE
hdr1_b       04FEDCBA98765432 0000000000000000 3 0 FEDCBA987654328899AABBCCDDEE
hdr2_b       0513579BDF02468A 0000000000000000 3 0 FEDCBA9876543213579BDF02468A
nop_mid      00FFFFFFFFFFFFFF 0000000000000000 3 0 FEDCBA9876543213579BDF02468A
unknown_7e   7E123456789ABCDE 0000000000000000 3 0 FEDCBA9876543213579BDF02468A
unknown_7e_b 7EFFFFFFFFFFFFFF 0000000000000000 3 0 FEDCBA9876543213579BDF02468A
echo_mid     810F1E2D3C4B5A69 0F1E2D3C4B5A6900 3 0 FEDCBA9876543213579BDF02468A
status_d     8600000000000000 3000000000000000 3 0 FEDCBA9876543213579BDF02468A
led_set_f    020000000000000F 0000000000000000 F 0 FEDCBA9876543213579BDF02468A
img_run_b    0300000000000001 0000000000000000 F 1 FEDCBA9876543213579BDF02468A
status_e     8600000000000000 F800000000000000 F 1 FEDCBA9876543213579BDF02468A
led_clear    0200000000000000 0000000000000000 0 1 FEDCBA9876543213579BDF02468A
status_f     8600000000000000 0800000000000000 0 1 FEDCBA9876543213579BDF02468A
hdr2_c       0500000000000000 0000000000000000 0 1 FEDCBA9876543200000000000000
hdr1_c       0400000000000000 0000000000000000 0 1 0000000000000000000000000000
echo_last    8180000000000001 8000000000000100 0 1 0000000000000000000000000000
nop_last     0000000000000000 0000000000000000 0 1 0000000000000000000000000000

// ==== build.f ====
rtl/spi_msg_pkg.sv
rtl/spi_msg_rx.sv
rtl/msg_regs.sv
rtl/spi_resp_tx.sv
rtl/spi_msg_top.sv
test/tb_spi_msg.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = tb_spi_msg
FILELIST   = build.f
OBJ_DIR    = obj_dir
VFLAGS     = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== test/tb_spi_msg.sv ====
module tb_spi_msg;

    timeunit 1ns;
    timeprecision 1ps;

    // ==================================================
    // Link timing and pattern file layout
    // ==================================================

    localparam string PATTERN_FILE = "test/spi_msg_patterns.txt";
    localparam int CLK_HALF = 10;
    localparam int CLK_PERIOD = 2 * CLK_HALF;
    localparam int RESET_CYCLES = 8;
    localparam int MSG_BITS = 64;
    localparam int RESP_BITS = 64;
    localparam int TURNAROUND = 8;
    // Start bit, message, turnaround, response and slack
    localparam int CYCLES_PER_MSG = 1 + 64 + 8 + 64 + 8;
    localparam int WATCHDOG_SLACK_NS = 1000;
    // Cycles allowed between the last message bit and the first response bit
    localparam int RESP_WAIT = TURNAROUND + 4;

    logic           spi_clk;
    logic           spi_rst_;
    logic           host_data;
    logic           line;
    logic           data_out;
    logic           data_oe;
    logic [3:0]     led;
    logic           img_rst_;
    logic [111:0]   header;

    string          name_q[$];
    logic [63:0]    msg_q[$];
    logic [63:0]    resp_q[$];
    logic [3:0]     led_q[$];
    logic           rst_q[$];
    logic [111:0]   hdr_q[$];

    logic           loaded;
    logic [31:0]    rng_state;

    // Pad model: DUT drives the line while data_oe is high
    assign line = data_oe ? data_out : host_data;

    spi_msg_top uut (
        .spi_clk  (spi_clk),
        .spi_rst_ (spi_rst_),
        .data_in  (line),
        .data_out (data_out),
        .data_oe  (data_oe),
        .led      (led),
        .img_rst_ (img_rst_),
        .header   (header)
    );

    initial spi_clk = 1'b0;
    always #CLK_HALF spi_clk = ~spi_clk;

    // ==================================================
    // Helpers
    // ==================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_failure(input string what);
        $display("Error: %s", what);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string test_name, input string field,
                               input logic [127:0] expected, input logic [127:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: %s expected %0h actual %0h",
                     test_name, field, expected, actual);
            $display("Test failed");
            $fatal(1, "run stopped");
        end
    endtask

    task automatic load_patterns();
        int             fd;
        int             n;
        string          text;
        logic [255:0]   name_buf;
        logic [63:0]    msg_word;
        logic [63:0]    resp_word;
        logic [3:0]     led_val;
        logic           rst_val;
        logic [111:0]   hdr_val;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            report_failure({"cannot open pattern file ", PATTERN_FILE});
        end
        while (!$feof(fd)) begin
            text = "";
            n = $fgets(text, fd);
            // Skip comments and blank lines
            if (n > 0 && text.len() > 1 && text.getc(0) != "#") begin
                n = $sscanf(text, "%s %h %h %h %h %h", name_buf, msg_word, resp_word,
                            led_val, rst_val, hdr_val);
                if (n != 6) begin
                    report_failure({"malformed pattern line: ", text});
                end
                name_q.push_back($sformatf("%0s", name_buf));
                msg_q.push_back(msg_word);
                resp_q.push_back(resp_word);
                led_q.push_back(led_val);
                rst_q.push_back(rst_val);
                hdr_q.push_back(hdr_val);
            end
        end
        $fclose(fd);
        if (msg_q.size() == 0) begin
            report_failure("pattern file holds no messages");
        end
    endtask

    // Idle line for 0 to 7 cycles
    task automatic idle_gap();
        int gap;
        rng_state = xorshift32(rng_state);
        gap = int'(rng_state % 8);
        repeat (gap) begin
            @(negedge spi_clk);
            host_data = 1'b0;
        end
    endtask

    // Start bit, then the word MSB first, then back to idle
    task automatic send_message(input logic [63:0] word);
        @(negedge spi_clk);
        host_data = 1'b1;
        for (int i = MSG_BITS - 1; i >= 0; i--) begin
            @(negedge spi_clk);
            host_data = word[i];
        end
        @(negedge spi_clk);
        host_data = 1'b0;
    endtask

    task automatic collect_response(input string test_name, output logic [63:0] data,
                                    output int nbits);
        int waited;
        data = '0;
        nbits = 0;
        waited = 0;
        while (!data_oe && waited < RESP_WAIT) begin
            @(negedge spi_clk);
            waited++;
        end
        if (!data_oe) begin
            report_failure({"no response driven for ", test_name});
        end
        while (data_oe && nbits < RESP_BITS + 4) begin
            data = {data[62:0], data_out};
            nbits++;
            @(negedge spi_clk);
        end
    endtask

    task automatic expect_silence(input string test_name);
        repeat (TURNAROUND + RESP_BITS) begin
            @(negedge spi_clk);
            if (data_oe) begin
                report_failure({"line driven after a message without response: ", test_name});
            end
        end
    endtask

    // ==================================================
    // Watchdog
    // ==================================================

    initial begin
        longint limit;
        wait (loaded);
        limit = longint'(msg_q.size()) * CYCLES_PER_MSG * CLK_PERIOD + WATCHDOG_SLACK_NS;
        #(limit);
        $display("Error: timeout, the run did not finish in %0d ns", limit);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        logic [63:0]    got_resp;
        int             nbits;
        string          tname;
        loaded = 1'b0;
        host_data = 1'b0;
        spi_rst_ = 1'b0;
        rng_state = 32'd13761;
        load_patterns();
        loaded = 1'b1;

        repeat (RESET_CYCLES) @(negedge spi_clk);
        spi_rst_ = 1'b1;
        @(negedge spi_clk);

        // State right after reset
        check_value("reset", "led", 128'(0), 128'(led));
        check_value("reset", "img_rst_", 128'(0), 128'(img_rst_));
        check_value("reset", "header", 128'(0), 128'(header));
        check_value("reset", "data_oe", 128'(0), 128'(data_oe));

        foreach (msg_q[i]) begin
            tname = name_q[i];
            idle_gap();
            send_message(msg_q[i]);
            // Bit 7 of the type code asks for a response
            if (msg_q[i][63]) begin
                collect_response(tname, got_resp, nbits);
                check_value(tname, "response bits", 128'(RESP_BITS), 128'(nbits));
                check_value(tname, "response", 128'(resp_q[i]), 128'(got_resp));
            end else begin
                expect_silence(tname);
            end
            check_value(tname, "led", 128'(led_q[i]), 128'(led));
            check_value(tname, "img_rst_", 128'(rst_q[i]), 128'(img_rst_));
            check_value(tname, "header", 128'(hdr_q[i]), 128'(header));
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== rtl/spi_msg_top.sv ====
module spi_msg_top (
    input  logic                                spi_clk,
    input  logic                                spi_rst_,
    input  logic                                data_in,
    output logic                                data_out,
    output logic                                data_oe,
    output logic [spi_msg_pkg::LED_WIDTH-1:0]   led,
    output logic                                img_rst_,
    output logic [spi_msg_pkg::HEADER_LEN-1:0]  header
);

    spi_msg_pkg::msg_t      msg;
    logic                   msg_valid;
    spi_msg_pkg::resp_req_t resp;
    logic                   busy;

    // ==================================================
    // Link receive side
    // ==================================================

    spi_msg_rx u_rx (
        .spi_clk   (spi_clk),
        .spi_rst_  (spi_rst_),
        .data_in   (data_in),
        .busy      (busy),
        .msg       (msg),
        .msg_valid (msg_valid)
    );

    // Register block steering LEDs, sensor reset and header
    msg_regs u_regs (
        .spi_clk   (spi_clk),
        .spi_rst_  (spi_rst_),
        .msg       (msg),
        .msg_valid (msg_valid),
        .led       (led),
        .img_rst_  (img_rst_),
        .header    (header),
        .resp      (resp)
    );

    // ==================================================
    // Link transmit side
    // ==================================================

    spi_resp_tx u_tx (
        .spi_clk   (spi_clk),
        .spi_rst_  (spi_rst_),
        .resp      (resp),
        .data_out  (data_out),
        .data_oe   (data_oe),
        .busy      (busy)
    );

endmodule

// ==== rtl/spi_resp_tx.sv ====
module spi_resp_tx (
    input  logic                    spi_clk,
    input  logic                    spi_rst_,
    input  spi_msg_pkg::resp_req_t  resp,
    output logic                    data_out,
    output logic                    data_oe,
    output logic                    busy
);

    localparam int CNT_W = $clog2(spi_msg_pkg::RESP_LEN);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_TURN,
        TX_SEND
    } tx_state_t;

    tx_state_t                          state;
    logic [CNT_W-1:0]                   cnt;
    logic [spi_msg_pkg::RESP_LEN-1:0]   shreg;

    // Strobe counts as busy so the receiver stays off the line at once
    assign busy = (state != TX_IDLE) || resp.send;

    // ==================================================
    // Turnaround and shift-out
    // ==================================================

    always_ff @(posedge spi_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            state    <= TX_IDLE;
            cnt      <= '0;
            data_oe  <= 1'b0;
            data_out <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (resp.send) begin
                        state <= TX_TURN;
                        cnt   <= CNT_W'(spi_msg_pkg::TURNAROUND_CYCLES - 1);
                    end
                end
                TX_TURN: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == '0) begin
                        state    <= TX_SEND;
                        cnt      <= CNT_W'(spi_msg_pkg::RESP_LEN - 1);
                        data_oe  <= 1'b1;
                        data_out <= shreg[spi_msg_pkg::RESP_LEN-1];
                    end
                end
                TX_SEND: begin
                    if (cnt == '0) begin
                        state    <= TX_IDLE;
                        data_oe  <= 1'b0;
                        data_out <= 1'b0;
                    end else begin
                        cnt      <= cnt - 1'b1;
                        data_out <= shreg[spi_msg_pkg::RESP_LEN-1];
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Loaded on the strobe, then shifted one bit per driven cycle
    always_ff @(posedge spi_clk) begin
        if (state == TX_IDLE && resp.send) begin
            shreg <= resp.data;
        end else if ((state == TX_TURN && cnt == '0) || (state == TX_SEND && cnt != '0)) begin
            shreg <= {shreg[spi_msg_pkg::RESP_LEN-2:0], 1'b0};
        end
    end

    a_oe_busy: assert property (
        @(posedge spi_clk) disable iff (!spi_rst_)
        data_oe |-> busy
    ) else $error("line driven outside a response");

endmodule

// ==== rtl/msg_regs.sv ====
module msg_regs (
    input  logic                                    spi_clk,
    input  logic                                    spi_rst_,
    input  spi_msg_pkg::msg_t                       msg,
    input  logic                                    msg_valid,
    output logic [spi_msg_pkg::LED_WIDTH-1:0]       led,
    output logic                                    img_rst_,
    output logic [spi_msg_pkg::HEADER_LEN-1:0]      header,
    output spi_msg_pkg::resp_req_t                  resp
);

    localparam int HDR_HI = spi_msg_pkg::HEADER_LEN - 1;
    localparam int HDR_MID = spi_msg_pkg::HEADER_PART_LEN;
    localparam int ECHO_PAD = spi_msg_pkg::RESP_LEN - spi_msg_pkg::MSG_ARG_LEN;
    localparam int STATUS_PAD = spi_msg_pkg::RESP_LEN - spi_msg_pkg::LED_WIDTH - 1;

    logic                               type_known;
    logic                               send_d;
    logic [spi_msg_pkg::RESP_LEN-1:0]   resp_data_d;
    logic                               resp_send;
    logic [spi_msg_pkg::RESP_LEN-1:0]   resp_data;

    // ==================================================
    // Decode
    // ==================================================

    always_comb begin
        type_known  = 1'b1;
        resp_data_d = '0;
        case (msg.msg_type)
            spi_msg_pkg::MSG_ECHO: begin
                resp_data_d = {msg.arg.echo, {ECHO_PAD{1'b0}}};
            end
            spi_msg_pkg::MSG_REG_STATUS: begin
                resp_data_d = {led, img_rst_, {STATUS_PAD{1'b0}}};
            end
            spi_msg_pkg::MSG_NOP,
            spi_msg_pkg::MSG_LED_SET,
            spi_msg_pkg::MSG_IMG_RESET,
            spi_msg_pkg::MSG_IMG_SET_HEADER1,
            spi_msg_pkg::MSG_IMG_SET_HEADER2: begin
                resp_data_d = '0;
            end
            // Unknown codes are dropped
            default: type_known = 1'b0;
        endcase
    end

    assign send_d = msg_valid && type_known && msg.msg_type[spi_msg_pkg::RESP_FLAG_BIT];

    // ==================================================
    // Registers
    // ==================================================

    always_ff @(posedge spi_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            led       <= '0;
            // Sensor held in reset until told otherwise
            img_rst_  <= 1'b0;
            header    <= '0;
            resp_send <= 1'b0;
        end else begin
            resp_send <= send_d;
            if (msg_valid) begin
                case (msg.msg_type)
                    spi_msg_pkg::MSG_LED_SET: begin
                        led <= msg.arg.led.val;
                    end
                    spi_msg_pkg::MSG_IMG_RESET: begin
                        img_rst_ <= msg.arg.rst.val;
                    end
                    spi_msg_pkg::MSG_IMG_SET_HEADER1: begin
                        header[HDR_HI:HDR_MID] <= msg.arg.hdr_part;
                    end
                    spi_msg_pkg::MSG_IMG_SET_HEADER2: begin
                        header[HDR_MID-1:0] <= msg.arg.hdr_part;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Response word follows every message
    always_ff @(posedge spi_clk) begin
        if (msg_valid) begin
            resp_data <= resp_data_d;
        end
    end

    assign resp.send = resp_send;
    assign resp.data = resp_data;

    // ==================================================
    // Checks
    // ==================================================

    a_send_after_msg: assert property (
        @(posedge spi_clk) disable iff (!spi_rst_)
        resp.send |-> !$past(resp.send)
    ) else $error("response strobe held for more than one cycle");

endmodule

// ==== rtl/spi_msg_rx.sv ====
module spi_msg_rx (
    input  logic                spi_clk,
    input  logic                spi_rst_,
    input  logic                data_in,
    input  logic                busy,
    output spi_msg_pkg::msg_t   msg,
    output logic                msg_valid
);

    localparam int CNT_W = $clog2(spi_msg_pkg::MSG_LEN);

    typedef enum logic {
        RX_IDLE,
        RX_SHIFT
    } rx_state_t;

    rx_state_t          state;
    logic [CNT_W-1:0]   bit_cnt;
    logic               listening;

    // Line is only watched when no response is pending
    assign listening = (state == RX_SHIFT) || !busy;

    // ==================================================
    // Sequencer
    // ==================================================

    always_ff @(posedge spi_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            state     <= RX_IDLE;
            bit_cnt   <= '0;
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    // Start bit is a single high cycle
                    if (!busy && data_in) begin
                        state   <= RX_SHIFT;
                        bit_cnt <= CNT_W'(spi_msg_pkg::MSG_LEN - 1);
                    end
                end
                RX_SHIFT: begin
                    bit_cnt <= bit_cnt - 1'b1;
                    if (bit_cnt == '0) begin
                        state     <= RX_IDLE;
                        msg_valid <= 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // MSB first into the bottom of the word
    always_ff @(posedge spi_clk) begin
        if (state == RX_SHIFT) begin
            msg <= spi_msg_pkg::msg_t'({msg[spi_msg_pkg::MSG_LEN-2:0], data_in});
        end
    end

    // ==================================================
    // Checks
    // ==================================================

    a_line_known: assert property (
        @(posedge spi_clk) disable iff (!spi_rst_)
        listening |-> !$isunknown(data_in)
    ) else $error("data_in unknown while the receiver listens");

endmodule

// ==== rtl/spi_msg_pkg.sv ====
package spi_msg_pkg;

    // ==================================================
    // Message and response framing
    // ==================================================

    // Message bits after the start bit
    localparam int MSG_LEN = 64;
    // Type code sits at the top of the message
    localparam int MSG_TYPE_LEN = 8;
    // Argument fills the rest
    localparam int MSG_ARG_LEN = 56;
    localparam int RESP_LEN = 64;

    // Idle cycles before the first response bit
    localparam int TURNAROUND_CYCLES = 8;

    // Type code bit that asks for a response
    localparam int RESP_FLAG_BIT = 7;

    // ==================================================
    // Register block sizes
    // ==================================================

    localparam int LED_WIDTH = 4;
    localparam int HEADER_LEN = 112;
    localparam int HEADER_PART_LEN = 56;

    // ==================================================
    // Type codes
    // ==================================================

    localparam logic [MSG_TYPE_LEN-1:0] MSG_NOP = 8'h00;
    localparam logic [MSG_TYPE_LEN-1:0] MSG_ECHO = 8'h81;
    localparam logic [MSG_TYPE_LEN-1:0] MSG_LED_SET = 8'h02;
    localparam logic [MSG_TYPE_LEN-1:0] MSG_IMG_RESET = 8'h03;
    localparam logic [MSG_TYPE_LEN-1:0] MSG_IMG_SET_HEADER1 = 8'h04;
    localparam logic [MSG_TYPE_LEN-1:0] MSG_IMG_SET_HEADER2 = 8'h05;
    localparam logic [MSG_TYPE_LEN-1:0] MSG_REG_STATUS = 8'h86;

    // ==================================================
    // Argument views
    // ==================================================

    // LED value in the low bits
    typedef struct packed {
        logic [MSG_ARG_LEN-LED_WIDTH-1:0] rsvd;
        logic [LED_WIDTH-1:0]             val;
    } led_arg_t;

    // Sensor reset level in bit 0
    typedef struct packed {
        logic [MSG_ARG_LEN-2:0] rsvd;
        logic                   val;
    } rst_arg_t;

    // One argument word, read per type
    typedef union packed {
        logic [MSG_ARG_LEN-1:0]     echo;
        led_arg_t                   led;
        rst_arg_t                   rst;
        logic [HEADER_PART_LEN-1:0] hdr_part;
    } msg_arg_u;

    typedef struct packed {
        logic [MSG_TYPE_LEN-1:0] msg_type;
        msg_arg_u                arg;
    } msg_t;

    typedef struct packed {
        logic                send;
        logic [RESP_LEN-1:0] data;
    } resp_req_t;

endpackage
